//--- r5p_config.svh
// width and register count for the execute slice
// the word groups need XLEN of 64, at 32 they decode as illegal
`ifndef R5P_CONFIG_SVH
`define R5P_CONFIG_SVH

////////////////////////////////////////
// core geometry
////////////////////////////////////////

`define XLEN    64  // data path width
`define GPR_NUM 32  // general purpose registers, x0 included

`endif

//--- riscv_isa_pkg.sv
// RV64I subset types shared by decoder, ALU and write-back
// wb_t data width follows XLEN from r5p_config.svh
`default_nettype none

`include "r5p_config.svh"

package riscv_isa_pkg;

  ////////////////////////////////////////
  // major opcodes
  ////////////////////////////////////////

  typedef enum logic [6:0] {
    OPC_LUI       = 7'b0110111,
    OPC_AUIPC     = 7'b0010111,
    OPC_OP_IMM    = 7'b0010011,
    OPC_OP        = 7'b0110011,
    OPC_OP_IMM_32 = 7'b0011011,  // word immediate ops
    OPC_OP_32     = 7'b0111011   // word register ops
  } opc_t;

  ////////////////////////////////////////
  // ALU control
  ////////////////////////////////////////

  // operand pair selection
  typedef enum logic [1:0] {
    AI_R1_R2 = 2'd0,  // rs1, rs2
    AI_R1_IM = 2'd1,  // rs1, imm
    AI_PC_IM = 2'd2   // pc, imm
  } ai_t;

  // result width
  typedef enum logic [1:0] {
    R_X  = 2'd0,  // full XLEN
    R_SW = 2'd1,  // signed word
    R_UW = 2'd2   // unsigned word
  } rt_t;

  // {funct7[5], funct3}, top bit doubles as invert flag for operand 2
  typedef enum logic [3:0] {
    AO_ADD  = 4'b0_000,
    AO_SUB  = 4'b1_000,
    AO_SLL  = 4'b0_001,
    AO_SLT  = 4'b0_010,
    AO_SLTU = 4'b0_011,
    AO_XOR  = 4'b0_100,
    AO_SRL  = 4'b0_101,
    AO_SRA  = 4'b1_101,
    AO_OR   = 4'b0_110,
    AO_AND  = 4'b0_111
  } ao_t;

  typedef struct packed {
    ai_t ai;  // input select
    ao_t ao;  // operation
    rt_t rt;  // result width
  } alu_t;

  ////////////////////////////////////////
  // write-back record
  ////////////////////////////////////////

  typedef struct packed {
    logic [4:0]       adr;  // destination register
    logic [`XLEN-1:0] dat;  // result
  } wb_t;

endpackage: riscv_isa_pkg

`default_nettype wire

//--- r5p_decode.sv
// combinational decoder for OP, OP-IMM, OP-32, OP-IMM-32, LUI and AUIPC
// everything else, loads, branches and CSRs included, raises ill
`default_nettype none

`include "r5p_config.svh"

module r5p_decode (
  input  logic [31:0]         ins,      // instruction word
  output riscv_isa_pkg::alu_t ctl,      // ALU control
  output logic [`XLEN-1:0]    imm,      // selected immediate
  output logic [4:0]          rs1_adr,  // source 1
  output logic [4:0]          rs2_adr,  // source 2
  output logic [4:0]          rd_adr,   // destination
  output logic                ill       // undecodable
);

  import riscv_isa_pkg::*;

  opc_t             opc;
  logic [2:0]       f3;
  logic [6:0]       f7;
  logic [`XLEN-1:0] imm_i;     // I-type, sign extended
  logic [`XLEN-1:0] imm_u;     // U-type, sign extended
  logic             no_word;   // word groups absent at XLEN 32
  logic             sh5_bad;   // shamt bit 5 set on a 32 bit core
  logic             f7_bad;    // funct7 other than 0000000 / 0100000

  assign opc = opc_t'(ins[6:0]);
  assign f3  = ins[14:12];
  assign f7  = ins[31:25];

  assign imm_i = `XLEN'($signed(ins[31:20]));
  assign imm_u = `XLEN'($signed({ins[31:12], 12'h000}));

  assign no_word = (`XLEN < 64);
  assign sh5_bad = no_word && ins[25];
  assign f7_bad  = ({f7[6], f7[4:0]} != 6'd0);

  // register fields, LUI adds imm to x0
  assign rs1_adr = (opc == OPC_LUI) ? 5'd0 : ins[19:15];
  assign rs2_adr = ins[24:20];
  assign rd_adr  = ins[11:7];

  always_comb begin
    ctl = '{ai: AI_R1_R2, ao: AO_ADD, rt: R_X};  // R-type, full width
    imm = imm_i;
    ill = 1'b0;
    case (opc)
      OPC_LUI: begin
        ctl.ai = AI_R1_IM;
        imm    = imm_u;
      end
      OPC_AUIPC: begin
        ctl.ai = AI_PC_IM;  // pc + imm
        imm    = imm_u;
      end
      OPC_OP_IMM: begin
        ctl.ai = AI_R1_IM;
        case (f3)
          3'b001: begin
            ctl.ao = AO_SLL;
            ill    = (ins[31:26] != 6'd0) || sh5_bad;  // shamt only
          end
          3'b101: begin
            ctl.ao = ins[30] ? AO_SRA : AO_SRL;
            ill    = ins[31] || (ins[29:26] != 4'd0) || sh5_bad;
          end
          default: ctl.ao = ao_t'({1'b0, f3});  // no SUB with immediate
        endcase
      end
      OPC_OP: begin
        ctl.ao = ao_t'({f7[5], f3});
        // bit 5 only legal on SUB and SRA
        ill = f7_bad || (f7[5] && (f3 != 3'b000) && (f3 != 3'b101));
      end
      OPC_OP_32: begin
        ctl.rt = R_SW;
        ctl.ao = ao_t'({f7[5], f3});
        ill    = no_word || f7_bad;
        if ((f3 != 3'b000) && (f3 != 3'b001) && (f3 != 3'b101)) begin
          ill = 1'b1;  // no word compares or logic
        end
        if (f7[5] && (f3 == 3'b001)) begin
          ill = 1'b1;  // no arithmetic left shift
        end
      end
      OPC_OP_IMM_32: begin
        ctl.ai = AI_R1_IM;
        ctl.rt = R_SW;
        ill    = no_word;
        case (f3)
          3'b000: ctl.ao = AO_ADD;  // ADDIW
          3'b001: begin
            ctl.ao = AO_SLL;
            ill    = no_word || (f7 != 7'd0);
          end
          3'b101: begin
            ctl.ao = f7[5] ? AO_SRA : AO_SRL;
            ill    = no_word || f7_bad;
          end
          default: ill = 1'b1;
        endcase
      end
      default: ill = 1'b1;  // unsupported major opcode
    endcase
  end

endmodule: r5p_decode

`default_nettype wire

//--- r5p_gpr.sv
// general purpose register file, 2 async reads and 1 sync write
// x0 is never written so it reads zero, read-after-write takes one edge
`default_nettype none

`include "r5p_config.svh"

module r5p_gpr (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                wen,      // write strobe
  input  riscv_isa_pkg::wb_t  wr,       // write address and data
  input  logic [4:0]          rs1_adr,
  input  logic [4:0]          rs2_adr,
  output logic [`XLEN-1:0]    rs1,
  output logic [`XLEN-1:0]    rs2
);

  import riscv_isa_pkg::*;

  logic [`XLEN-1:0] gpr [`GPR_NUM];  // register array

  ////////////////////////////////////////
  // write port
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `GPR_NUM; i++) begin
        gpr[i] <= '0;
      end
    end else if (wen && (wr.adr != 5'd0)) begin
      gpr[wr.adr] <= wr.dat;  // x0 stays zero
    end
  end

  ////////////////////////////////////////
  // read ports
  ////////////////////////////////////////

  assign rs1 = gpr[rs1_adr];
  assign rs2 = gpr[rs2_adr];

endmodule: r5p_gpr

`default_nettype wire

//--- r5p_alu.sv
// combinational ALU, word ops handle the low 32 bits and sign extend
// clk and rst_n are unused here and reserved for a pipelined variant
`default_nettype none

`include "r5p_config.svh"

module r5p_alu #(
  parameter int unsigned XLEN = `XLEN
)(
  input  logic                clk,
  input  logic                rst_n,
  input  riscv_isa_pkg::alu_t ctl,   // from decoder
  input  logic [XLEN-1:0]     imm,   // immediate
  input  logic [XLEN-1:0]     pc,    // instruction address
  input  logic [XLEN-1:0]     rs1,   // source 1 data
  input  logic [XLEN-1:0]     rs2,   // source 2 data
  output logic [XLEN-1:0]     rd     // result
);

  import riscv_isa_pkg::*;

  localparam int unsigned SAW = $clog2(XLEN);  // shift amount width

  logic [XLEN-1:0] in1;  // selected input 1
  logic [XLEN-1:0] in2;  // selected input 2
  logic [XLEN-1:0] op1;  // input 1 after word narrowing
  logic [XLEN-1:0] op2;  // input 2, maybe inverted
  logic            inv;  // subtract
  logic            sgn;  // keep sign of a narrowed word
  logic [SAW-1:0]  sa;   // shift amount
  logic [XLEN-1:0] sum;
  logic [XLEN-1:0] val;  // full width result

  ////////////////////////////////////////
  // operand selection
  ////////////////////////////////////////

  always_comb begin
    case (ctl.ai)
      AI_R1_IM: begin
        in1 = rs1;
        in2 = imm;
      end
      AI_PC_IM: begin
        in1 = pc;
        in2 = imm;
      end
      default: begin
        in1 = rs1;
        in2 = rs2;
      end
    endcase
  end

  // SRLW needs zeros above bit 31, SRAW the sign
  assign sgn = (ctl.rt == R_SW) && (ctl.ao == AO_SRA);

  always_comb begin
    case (ctl.rt)
      R_SW, R_UW: op1 = sgn ? XLEN'($signed(in1[31:0])) : XLEN'(in1[31:0]);
      default:    op1 = in1;
    endcase
  end

  assign inv = ctl.ao[3];  // funct7 bit 5
  assign op2 = inv ? ~in2 : in2;

  // two's complement subtract via carry in
  assign sum = op1 + op2 + XLEN'(inv);

  // 6 bit amount at 64, 5 bit for words
  assign sa = (ctl.rt == R_X) ? in2[SAW-1:0] : SAW'(in2[4:0]);

  ////////////////////////////////////////
  // operations
  ////////////////////////////////////////

  always_comb begin
    case (ctl.ao)
      AO_ADD,
      AO_SUB:  val = sum;
      AO_SLT:  val = XLEN'($signed(in1) < $signed(in2));
      AO_SLTU: val = XLEN'(in1 < in2);
      AO_XOR:  val = in1 ^ in2;
      AO_OR:   val = in1 | in2;
      AO_AND:  val = in1 & in2;
      AO_SLL:  val = op1 << sa;                 // barrel shifter
      AO_SRL:  val = op1 >> sa;
      AO_SRA:  val = $unsigned($signed(op1) >>> sa);
      default: val = sum;
    endcase
  end

  // word results sign extend from bit 31
  assign rd = (ctl.rt == R_X) ? val : XLEN'($signed(val[31:0]));

endmodule: r5p_alu

`default_nettype wire

//--- r5p_exec.sv
// execute slice top, one instruction per vld strobe, no back-pressure
// write-back port and ill are registered, fixed latency of one cycle
`default_nettype none

`include "r5p_config.svh"

module r5p_exec (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               vld,     // instruction strobe
  input  logic [31:0]        ins,     // instruction word
  input  logic [`XLEN-1:0]   pc,      // its address
  output logic               wb_vld,  // retirement strobe
  output riscv_isa_pkg::wb_t wb,      // destination and result
  output logic               ill      // illegal instruction pulse
);

  import riscv_isa_pkg::*;

  alu_t             ctl;
  logic [`XLEN-1:0] imm;
  logic [4:0]       rs1_adr;
  logic [4:0]       rs2_adr;
  logic [4:0]       rd_adr;
  logic             dec_ill;
  logic [`XLEN-1:0] rs1;
  logic [`XLEN-1:0] rs2;
  logic [`XLEN-1:0] rd;
  logic             wen;
  wb_t              wb_nxt;  // record written at the closing edge

  r5p_decode u_dec (
    .ins     (ins),
    .ctl     (ctl),
    .imm     (imm),
    .rs1_adr (rs1_adr),
    .rs2_adr (rs2_adr),
    .rd_adr  (rd_adr),
    .ill     (dec_ill)
  );

  r5p_gpr u_gpr (
    .clk     (clk),
    .rst_n   (rst_n),
    .wen     (wen),
    .wr      (wb_nxt),
    .rs1_adr (rs1_adr),
    .rs2_adr (rs2_adr),
    .rs1     (rs1),
    .rs2     (rs2)
  );

  r5p_alu #(
    .XLEN (`XLEN)
  ) u_alu (
    .clk   (clk),
    .rst_n (rst_n),
    .ctl   (ctl),
    .imm   (imm),
    .pc    (pc),
    .rs1   (rs1),
    .rs2   (rs2),
    .rd    (rd)
  );

  assign wb_nxt = '{adr: rd_adr, dat: rd};
  assign wen    = vld && !dec_ill && (rd_adr != 5'd0);  // legal, not x0

  ////////////////////////////////////////
  // write-back register
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_vld <= 1'b0;
      ill    <= 1'b0;
      wb     <= '0;
    end else begin
      wb_vld <= vld && !dec_ill;  // x0 targets still retire
      ill    <= vld && dec_ill;
      if (vld) begin
        wb <= wb_nxt;             // hold last record otherwise
      end
    end
  end

endmodule: r5p_exec

`default_nettype wire

//--- r5p_exec_props.sv
// port rules of r5p_exec, bound into every instance
// retire and illegal pulses follow the strobe by exactly one cycle
`default_nettype none

module r5p_exec_props (
  input logic clk,
  input logic rst_n,
  input logic vld,     // instruction strobe
  input logic wb_vld,  // retirement
  input logic ill      // illegal pulse
);

  ////////////////////////////////////////
  // output rules
  ////////////////////////////////////////

  // a retirement is never illegal
  excl_chk: assert property (@(posedge clk) disable iff (!rst_n) !(wb_vld && ill))
    else $error("wb_vld and ill high in the same cycle");

  // nothing comes out without a strobe one cycle before
  cause_chk: assert property (@(posedge clk) disable iff (!rst_n)
                              (wb_vld || ill) |-> $past(vld))
    else $error("wb_vld or ill without vld in the previous cycle");

  // quiet while reset holds
  reset_chk: assert property (@(posedge clk) !rst_n |-> (!wb_vld && !ill))
    else $error("wb_vld or ill high during reset");

endmodule: r5p_exec_props

bind r5p_exec r5p_exec_props u_props (
  .clk    (clk),
  .rst_n  (rst_n),
  .vld    (vld),
  .wb_vld (wb_vld),
  .ill    (ill)
);

`default_nettype wire

//--- r5p_exec_tb.sv
// random ALU traffic for r5p_exec, a model register file predicts every result
// assumes XLEN 64; the result of an instruction is checked one cycle after its strobe
`default_nettype none

`include "r5p_config.svh"

module r5p_exec_tb;

  import riscv_isa_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int N_TOTAL    = 31 + 300 + 300 + 200 + 100 + 2 * 100 + 2 * 50;  // strobes

  typedef struct packed {
    logic vld;  // expect retirement
    logic ill;  // expect illegal pulse
    logic chk;  // compare wb too
    wb_t  wb;
  } exp_t;

  logic             clk;
  logic             rst_n;
  logic             vld;
  logic [31:0]      ins;
  logic [`XLEN-1:0] pc;
  logic             wb_vld;
  wb_t              wb;
  logic             ill;

  logic [31:0] seed;             // xorshift state
  logic [63:0] mreg [`GPR_NUM];  // model GPRs
  exp_t        exp_q [$];        // one record per cycle
  string       name_q [$];

  r5p_exec UUT (
    .clk    (clk),
    .rst_n  (rst_n),
    .vld    (vld),
    .ins    (ins),
    .pc     (pc),
    .wb_vld (wb_vld),
    .wb     (wb),
    .ill    (ill)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // every strobe takes at most two cycles, reset fits in the margin
  initial begin
    #((N_TOTAL * 2 + 100) * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, DUT stopped retiring", N_TOTAL * 2 + 100);
    $display("Test failed");
    $fatal(1, "timeout");
  end

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////

  function automatic logic [31:0] rnd();
    seed = seed ^ (seed << 13);
    seed = seed ^ (seed >> 17);
    seed = seed ^ (seed << 5);
    return seed;
  endfunction

  // RV64I rules, returns 0 when the word is not in the supported groups
  function automatic logic model_exec(input logic [31:0] i, input logic [63:0] p,
                                      output logic [63:0] res);
    logic [63:0] a;
    logic [63:0] b;
    logic [31:0] w;
    logic [5:0]  sh;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic        ok;
    a  = mreg[i[19:15]];
    b  = (i[6:0] == OPC_OP || i[6:0] == OPC_OP_32) ? mreg[i[24:20]]
                                                   : {{52{i[31]}}, i[31:20]};
    f3 = i[14:12];
    f7 = i[31:25];
    ok = 1'b1;
    w  = '0;
    res = '0;
    case (i[6:0])
      OPC_LUI:   res = {{32{i[31]}}, i[31:12], 12'h000};
      OPC_AUIPC: res = p + {{32{i[31]}}, i[31:12], 12'h000};
      OPC_OP, OPC_OP_IMM: begin
        sh = b[5:0];  // 6 bit shamt, register or immediate
        if (i[6:0] == OPC_OP)
          ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
        else if (f3 == 3'b001)
          ok = (i[31:26] == 6'd0);
        else if (f3 == 3'b101)
          ok = (i[31:26] == 6'd0) || (i[31:26] == 6'b010000);
        case (f3)
          3'b000: res = (i[6:0] == OPC_OP && f7[5]) ? a - b : a + b;
          3'b001: res = a << sh;
          3'b010: res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
          3'b011: res = (a < b) ? 64'd1 : 64'd0;
          3'b100: res = a ^ b;
          3'b101: begin
            if (i[30])
              res = $signed(a) >>> sh;
            else
              res = a >> sh;
          end
          3'b110: res = a | b;
          default: res = a & b;
        endcase
      end
      OPC_OP_32, OPC_OP_IMM_32: begin
        sh = {1'b0, b[4:0]};  // word shifts use 5 bits
        if (i[6:0] == OPC_OP_32)
          ok = (f7 == 7'h00 && (f3 == 3'b000 || f3 == 3'b001 || f3 == 3'b101)) ||
               (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
        else
          ok = (f3 == 3'b000) || (f3 == 3'b001 && f7 == 7'h00) ||
               (f3 == 3'b101 && (f7 == 7'h00 || f7 == 7'h20));
        case (f3)
          3'b000: w = (i[6:0] == OPC_OP_32 && f7[5]) ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
          3'b001: w = a[31:0] << sh;
          3'b101: begin
            if (f7[5])
              w = $signed(a[31:0]) >>> sh;
            else
              w = a[31:0] >> sh;
          end
          default: w = '0;
        endcase
        res = {{32{w[31]}}, w};  // sign extend from bit 31
      end
      default: ok = 1'b0;
    endcase
    return ok;
  endfunction

  // random legal word; kind 0 OP-IMM, 1 OP, 2 word groups
  task automatic gen_alu(input int kind, output logic [31:0] i);
    logic [31:0] r;
    logic [31:0] s;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [3:0]  sel;
    r   = rnd();
    s   = rnd();
    f3  = r[2:0];
    sel = r[31:28] % 4'd9;  // ADDW SUBW SLLW SRLW SRAW ADDIW SLLIW SRLIW SRAIW
    if (kind == 0) begin
      i = {s[11:0], r[7:3], f3, r[12:8], OPC_OP_IMM};
      if (f3 == 3'b001 || f3 == 3'b101)
        i[31:26] = {1'b0, r[18] && f3[2], 4'd0};  // SRAI only on right shifts
    end else if (kind == 1) begin
      f7 = (r[18] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00;
      i  = {f7, s[4:0], r[7:3], f3, r[12:8], OPC_OP};
    end else begin
      f3 = (sel == 4'd0 || sel == 4'd1 || sel == 4'd5) ? 3'b000 :
           (sel == 4'd2 || sel == 4'd6) ? 3'b001 : 3'b101;
      f7 = (sel == 4'd1 || sel == 4'd4 || sel == 4'd8) ? 7'h20 : 7'h00;
      if (sel == 4'd5)
        i = {s[11:0], r[7:3], f3, r[12:8], OPC_OP_IMM_32};
      else
        i = {f7, s[4:0], r[7:3], f3, r[12:8], (sel < 4'd5) ? OPC_OP_32 : OPC_OP_IMM_32};
    end
  endtask

  task automatic gen_illegal(output logic [31:0] i);
    logic [31:0] r;
    r = rnd();
    i = rnd();
    case (r[1:0])
      2'd0: begin
        while (i[6:0] inside {OPC_LUI, OPC_AUIPC, OPC_OP, OPC_OP_IMM, OPC_OP_32, OPC_OP_IMM_32})
          i = rnd();  // unknown major opcode
      end
      2'd1: begin
        i[6:0] = OPC_OP;
        i[25]  = 1'b1;  // funct7 neither 00 nor 20
      end
      2'd2: begin
        i[6:0]   = OPC_OP;
        i[31:25] = 7'h20;
        i[14:12] = {r[4], 1'b1, r[3]};  // SLT SLTU OR AND with bit 5
      end
      default: begin
        i[6:0]   = r[2] ? OPC_OP_32 : OPC_OP_IMM_32;
        i[14:12] = {r[4], 1'b1, r[3]};  // no word compares or logic
      end
    endcase
  endtask

  ////////////////////////////////////////
  // drive and check
  ////////////////////////////////////////

  task automatic report_mismatch(input string nm, input string what,
                                 input logic [63:0] exp_v, input logic [63:0] act_v);
    $display("Mismatch %s %s expected %h actual %h", nm, what, exp_v, act_v);
    $display("Test failed");
    $fatal(1, "check failed");
  endtask

  task automatic check_outputs();
    exp_t  e;
    string nm;
    e  = exp_q.pop_front();
    nm = name_q.pop_front();
    assert (wb_vld === e.vld)
      else report_mismatch(nm, "wb_vld", 64'(e.vld), 64'(wb_vld));
    assert (ill === e.ill)
      else report_mismatch(nm, "ill", 64'(e.ill), 64'(ill));
    if (e.chk) begin
      assert (wb.adr === e.wb.adr)
        else report_mismatch(nm, "wb.adr", 64'(e.wb.adr), 64'(wb.adr));
      assert (wb.dat === e.wb.dat)
        else report_mismatch(nm, "wb.dat", e.wb.dat, wb.dat);
    end
  endtask

  // one cycle, outputs of the previous strobe are settled 1 unit past the edge
  task automatic step(input logic v, input logic [31:0] i, input logic [63:0] p,
                      input string nm);
    exp_t        e;
    logic        ok;
    logic [63:0] res;
    @(posedge clk);
    #1;
    check_outputs();
    vld = v;
    ins = i;
    pc  = p;
    e   = '0;
    if (v) begin
      ok        = model_exec(i, p, res);
      e.vld     = ok;
      e.ill     = !ok;
      e.chk     = ok;  // wb is don't care on ill
      e.wb.adr  = i[11:7];
      e.wb.dat  = res;
      if (ok && (i[11:7] != 5'd0))
        mreg[i[11:7]] = res;
    end
    exp_q.push_back(e);
    name_q.push_back($sformatf("%s ins %h", nm, i));
  endtask

  // mostly back to back, now and then a gap
  task automatic issue(input logic [31:0] i, input logic [63:0] p, input string nm);
    logic [31:0] r;
    r = rnd();
    if (r[2:0] == 3'd0)
      step(1'b0, '0, '0, "idle");
    step(1'b1, i, p, nm);
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    logic [31:0] i;
    logic [31:0] r;
    logic [63:0] p;
    exp_t        rst_e;
    rst_n  = 1'b0;
    vld    = 1'b0;
    ins    = '0;
    pc     = '0;
    seed   = 32'h449d_6ace;
    for (int n = 0; n < `GPR_NUM; n++)
      mreg[n] = '0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    rst_e     = '0;
    rst_e.chk = 1'b1;  // wb must read zero
    exp_q.push_back(rst_e);
    name_q.push_back("reset");

    for (int n = 1; n < 32; n++) begin  // xn + imm gives the bare immediate only if xn reset to 0
      r = rnd();
      issue({r[11:0], 5'(n), 3'b000, 5'(n), OPC_OP_IMM}, '0, "reset addi");
    end
    repeat (300) begin
      gen_alu(0, i);
      issue(i, '0, "op_imm");
    end
    repeat (300) begin
      gen_alu(1, i);
      issue(i, '0, "op");
    end
    repeat (200) begin
      gen_alu(2, i);
      issue(i, '0, "word");
    end
    repeat (100) begin  // LUI and AUIPC with random pc
      r      = rnd();
      p      = {rnd(), rnd()};
      p[1:0] = 2'b00;
      i      = rnd();
      i[6:0] = r[0] ? OPC_LUI : OPC_AUIPC;
      issue(i, p, "upper");
    end
    repeat (100) begin
      gen_illegal(i);
      issue(i, p, "illegal");
      issue({12'h000, i[11:7], 3'b000, i[11:7], OPC_OP_IMM}, '0, "illegal readback");
    end
    repeat (50) begin
      r = rnd();
      gen_alu(int'(r[1:0] % 2'd3), i);
      i[11:7] = 5'd0;
      issue(i, '0, "x0 write");
      issue({7'h00, 5'd0, 5'd0, 3'b110, r[8:4], OPC_OP}, '0, "x0 read");  // OR rd, x0, x0
    end

    step(1'b0, '0, '0, "drain");
    @(posedge clk);
    #1;
    check_outputs();
    $display("Test passed");
    $finish;
  end

endmodule: r5p_exec_tb

`default_nettype wire

//--- verilog.f
+incdir+.
riscv_isa_pkg.sv
r5p_decode.sv
r5p_gpr.sv
r5p_alu.sv
r5p_exec.sv
r5p_exec_props.sv
r5p_exec_tb.sv

//--- run.sh
#!/bin/sh
# builds the r5p_exec testbench with Verilator and runs it, exit status is the result
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -f verilog.f --top-module r5p_exec_tb \
       -o r5p_exec_sim \
  && ./obj_dir/r5p_exec_sim \
  || exit 1
